//--- verilog/seq_settings.svh
`ifndef SEQ_SETTINGS_SVH
`define SEQ_SETTINGS_SVH

// Interleaved threads, one bank each
`define SEQ_N_THREADS 4

// Program memory address width, 64 words
`define SEQ_PROG_AW 6

`define SEQ_FIELD_W 7   // Operand field inside a bank
`define SEQ_THREAD_W 2  // Bank prefix

`endif

//--- verilog/seq_isa_pkg.sv
`default_nettype none
`include "seq_settings.svh"

package seq_isa_pkg;

    typedef logic [`SEQ_PROG_AW-1:0] prog_addr_t;
    typedef logic [`SEQ_FIELD_W-1:0] field_t;
    typedef logic [1:0]              step_cnt_t;

    typedef enum logic [2:0] {
        JMP     = 3'd0,
        CALL    = 3'd1,
        RET     = 3'd2,
        HALT    = 3'd3,
        FP2_MUL = 3'd4,
        FP2_SQR = 3'd5,
        ACC_SUB = 3'd6
    } opcode_t;

    typedef struct packed {
        opcode_t opcode;
        field_t  dst;   // Low bits are the JMP/CALL target
        field_t  src0;  // Frame offset for CALL
        field_t  src1;
    } instr_t;

    // Datapath controls, same field order as the pairing core
    typedef struct packed {
        logic [1:0] pos;
        logic [2:0] pom3;
        logic [2:0] pom2;
        logic [2:0] pom1;
        logic [2:0] cm;
        logic [1:0] pm;
    } csig_t;

    function automatic step_cnt_t op_steps(opcode_t op);
        case (op)
            FP2_MUL:          return 2'd3;
            FP2_SQR, ACC_SUB: return 2'd2;
            default:          return 2'd1;  // Control ops take one pass over the threads
        endcase
    endfunction

    //////////////////////////////////////////////////
    // Microcode steps  {pos, pom3, pom2, pom1, cm, pm}
    //////////////////////////////////////////////////
    function automatic csig_t mop_table(opcode_t op, step_cnt_t step);
        csig_t c;
        c = '0;
        case (op)
            FP2_MUL: begin
                case (step)
                    2'd0:    c = csig_t'({2'b00, 3'b000, 3'b001, 3'b001, 3'b001, 2'b00});
                    2'd1:    c = csig_t'({2'b00, 3'b000, 3'b010, 3'b100, 3'b001, 2'b00});
                    2'd2:    c = csig_t'({2'b01, 3'b000, 3'b011, 3'b000, 3'b001, 2'b10});
                    default: c = '0;
                endcase
            end
            FP2_SQR: begin
                case (step)
                    2'd0:    c = csig_t'({2'b01, 3'b000, 3'b001, 3'b000, 3'b010, 2'b00});
                    2'd1:    c = csig_t'({2'b00, 3'b000, 3'b000, 3'b001, 3'b001, 2'b01});
                    default: c = '0;
                endcase
            end
            ACC_SUB: begin
                case (step)
                    2'd0:    c = csig_t'({2'b00, 3'b000, 3'b000, 3'b001, 3'b001, 2'b00});
                    2'd1:    c = csig_t'({2'b00, 3'b000, 3'b000, 3'b100, 3'b001, 2'b00});
                    default: c = '0;
                endcase
            end
            default: c = '0;  // NOP
        endcase
        return c;
    endfunction

endpackage

`default_nettype wire

//--- verilog/seq_pipe_pkg.sv
`default_nettype none
`include "seq_settings.svh"

package seq_pipe_pkg;

    import seq_isa_pkg::*;

    localparam int BANK_AW = `SEQ_THREAD_W + `SEQ_FIELD_W;

    typedef logic [`SEQ_THREAD_W-1:0] thread_id_t;
    typedef logic [BANK_AW-1:0]       bank_addr_t;  // Thread prefix over field

    // Fetch to lanes, broadcast every cycle
    typedef struct packed {
        logic       valid;
        opcode_t    opcode;
        step_cnt_t  step;
        thread_id_t slot;
        field_t     dst;
        field_t     src0;
        field_t     src1;
        field_t     frame;
    } issue_t;

    // Lane to issue stage
    typedef struct packed {
        logic       valid;
        opcode_t    opcode;
        step_cnt_t  step;
        bank_addr_t dst;
        bank_addr_t src0;
        bank_addr_t src1;
    } lane_out_t;

    typedef struct packed {
        csig_t      csig;
        bank_addr_t dst;
        bank_addr_t src0;
        bank_addr_t src1;
    } mop_t;

endpackage

`default_nettype wire

//--- verilog/seq_fetch.sv
`timescale 1ns/1ps
`default_nettype none
`include "seq_settings.svh"

module seq_fetch import seq_isa_pkg::*, seq_pipe_pkg::*; (
    input  logic       clk,
    input  logic       rstn,
    input  logic       prog_we,
    input  prog_addr_t prog_addr,
    input  instr_t     prog_data,
    input  logic       run,
    output logic       busy,
    output issue_t     issue
);

    localparam int PROG_DEPTH = 1 << `SEQ_PROG_AW;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_READ,   // Read bubble while the memory output settles
        ST_ISSUE
    } fetch_state_t;

    fetch_state_t state;
    instr_t       prog_mem [PROG_DEPTH];
    instr_t       instr;      // Memory output at pc
    prog_addr_t   pc;
    prog_addr_t   ret_addr;
    prog_addr_t   jmp_target;
    field_t       frame;
    thread_id_t   slot;
    step_cnt_t    step;
    logic         is_arith;
    logic         last_slot;
    logic         last_step;

    assign jmp_target = prog_addr_t'(instr.dst);
    assign is_arith   = instr.opcode inside {FP2_MUL, FP2_SQR, ACC_SUB};
    assign last_slot  = (slot == thread_id_t'(`SEQ_N_THREADS - 1));
    assign last_step  = (step == op_steps(instr.opcode) - 2'd1);
    assign busy       = (state != ST_IDLE);

    //////////////////////////////////////////////////
    // Program memory
    //////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (prog_we && state == ST_IDLE) begin  // Loader only while idle
            prog_mem[prog_addr] <= prog_data;
        end
        instr <= prog_mem[pc];
    end

    //////////////////////////////////////////////////
    // Run state, counters and control flow
    //////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rstn) begin
            state    <= ST_IDLE;
            pc       <= '0;
            ret_addr <= '0;
            frame    <= '0;
            slot     <= '0;
            step     <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (run) begin
                        state <= ST_READ;
                        pc    <= '0;
                    end
                end
                ST_READ: begin
                    state <= ST_ISSUE;
                    slot  <= '0;
                    step  <= '0;
                end
                ST_ISSUE: begin
                    if (!last_slot) begin
                        slot <= slot + 1'b1;
                    end else if (!last_step) begin
                        slot <= '0;                 // Step-major, back to thread 0
                        step <= step + 1'b1;
                    end else begin
                        state <= ST_READ;
                        case (instr.opcode)
                            JMP: pc <= jmp_target;
                            CALL: begin
                                ret_addr <= pc + 1'b1;
                                pc       <= jmp_target;
                                frame    <= instr.src0;  // Stays until the next CALL
                            end
                            RET: pc <= ret_addr;
                            HALT: begin
                                pc    <= '0;
                                state <= ST_IDLE;
                            end
                            default: pc <= pc + 1'b1;
                        endcase
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Broadcast word, control ops go out with valid low
    always_comb begin
        issue.valid  = (state == ST_ISSUE) && is_arith;
        issue.opcode = instr.opcode;
        issue.step   = step;
        issue.slot   = slot;
        issue.dst    = instr.dst;
        issue.src0   = instr.src0;
        issue.src1   = instr.src1;
        issue.frame  = frame;
    end

endmodule

`default_nettype wire

//--- verilog/thread_lane.sv
`timescale 1ns/1ps
`default_nettype none

module thread_lane import seq_isa_pkg::*, seq_pipe_pkg::*; #(
    parameter int LANE_ID = 0
) (
    input  logic      clk,
    input  logic      rstn,
    input  issue_t    issue,
    output lane_out_t lane_out
);

    logic hit;

    assign hit = issue.valid && (issue.slot == thread_id_t'(LANE_ID));

    // Bank prefix over the frame-relative field
    function automatic bank_addr_t bank_addr(field_t field, field_t frame);
        field_t offs;
        offs = field + frame;  // Wraps at 128
        return {thread_id_t'(LANE_ID), offs};
    endfunction

    always_ff @(posedge clk) begin
        if (!rstn) begin
            lane_out.valid <= 1'b0;
        end else begin
            lane_out.valid <= hit;
        end
    end

    always_ff @(posedge clk) begin
        if (hit) begin
            lane_out.opcode <= issue.opcode;
            lane_out.step   <= issue.step;
            lane_out.dst    <= bank_addr(issue.dst, issue.frame);
            lane_out.src0   <= bank_addr(issue.src0, issue.frame);
            lane_out.src1   <= bank_addr(issue.src1, issue.frame);
        end
    end

endmodule

`default_nettype wire

//--- verilog/mop_issue.sv
`timescale 1ns/1ps
`default_nettype none
`include "seq_settings.svh"

module mop_issue import seq_isa_pkg::*, seq_pipe_pkg::*; (
    input  logic      clk,
    input  logic      rstn,
    input  lane_out_t lanes [`SEQ_N_THREADS],
    output logic      mop_valid,
    output mop_t      mop
);

    lane_out_t sel;

    // At most one lane holds a micro-op in any cycle
    always_comb begin
        sel = '0;
        for (int i = 0; i < `SEQ_N_THREADS; i++) begin
            if (lanes[i].valid) begin
                sel = lanes[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            mop_valid <= 1'b0;
        end else begin
            mop_valid <= sel.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (sel.valid) begin
            mop.csig <= mop_table(sel.opcode, sel.step);  // Step expansion
            mop.dst  <= sel.dst;
            mop.src0 <= sel.src0;
            mop.src1 <= sel.src1;
        end
    end

endmodule

`default_nettype wire

//--- verilog/microcode_sequencer.sv
`timescale 1ns/1ps
`default_nettype none
`include "seq_settings.svh"

module microcode_sequencer import seq_isa_pkg::*, seq_pipe_pkg::*; (
    input  logic       clk,
    input  logic       rstn,
    input  logic       prog_we,
    input  prog_addr_t prog_addr,
    input  instr_t     prog_data,
    input  logic       run,
    output logic       busy,
    output logic       mop_valid,
    output mop_t       mop
);

    issue_t    issue;
    lane_out_t lane_outs [`SEQ_N_THREADS];

    seq_fetch i_seq_fetch (
        .clk       (clk),
        .rstn      (rstn),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .run       (run),
        .busy      (busy),
        .issue     (issue)
    );

    // One lane per thread, each picks its own slot
    for (genvar g = 0; g < `SEQ_N_THREADS; g++) begin : g_lane
        thread_lane #(
            .LANE_ID (g)
        ) i_thread_lane (
            .clk      (clk),
            .rstn     (rstn),
            .issue    (issue),
            .lane_out (lane_outs[g])
        );
    end

    mop_issue i_mop_issue (
        .clk       (clk),
        .rstn      (rstn),
        .lanes     (lane_outs),
        .mop_valid (mop_valid),
        .mop       (mop)
    );

endmodule

`default_nettype wire

//--- sim/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter int HALF_PERIOD  = 5,   // 10 ns clock
    parameter int RESET_CYCLES = 16
) (
    output logic clk,
    output logic rstn
);

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    initial begin
        rstn <= 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rstn <= 1'b1;
    end

endmodule

`default_nettype wire

//--- sim/tb_checker.sv
`timescale 1ns/1ps
`default_nettype none
`include "seq_settings.svh"

module tb_checker import seq_isa_pkg::*, seq_pipe_pkg::*; (
    input  logic   clk,
    input  logic   rstn,
    input  logic   run,
    input  logic   busy,
    input  logic   mop_valid,
    input  mop_t   mop,
    input  instr_t prog [1 << `SEQ_PROG_AW],
    output int     tests_done,
    output int     tests_failed,
    output int     error_count
);

    localparam int PROG_DEPTH = 1 << `SEQ_PROG_AW;
    localparam int FIELD_SPAN = 1 << `SEQ_FIELD_W;
    localparam int MAX_INSTR  = 256;  // Guards against a looping program

    mop_t want_q [$];
    mop_t want;
    int   frame_model;
    int   ret_model;
    int   test_errors;
    int   beats;
    logic in_test;
    logic started;
    logic run_q;
    logic busy_q;

    // Reference step tables, {pos, pom3, pom2, pom1, cm, pm}
    function automatic logic [15:0] step_csig(opcode_t op, int step);
        case (op)
            FP2_MUL: return (step == 0) ? 16'h0124 : (step == 1) ? 16'h0284 : 16'h4306;
            FP2_SQR: return (step == 0) ? 16'h4108 : 16'h0025;
            ACC_SUB: return (step == 0) ? 16'h0024 : 16'h0084;
            default: return 16'h0000;
        endcase
    endfunction

    function automatic int step_count(opcode_t op);
        case (op)
            FP2_MUL:          return 3;
            FP2_SQR, ACC_SUB: return 2;
            default:          return 0;  // Control ops issue nothing
        endcase
    endfunction

    function automatic bank_addr_t thread_addr(int thread, field_t field, int frame);
        return bank_addr_t'(thread * FIELD_SPAN + (int'(field) + frame) % FIELD_SPAN);
    endfunction

    task automatic report_error(string msg);
        $display("%0t: %s", $time, msg);
        error_count++;
        test_errors++;
    endtask

    task automatic compare_field(string name, logic [15:0] expected, logic [15:0] actual);
        if (expected !== actual) begin
            $display("ERR %0t %s expected %h got %h", $time, name, expected, actual);
            error_count++;
            test_errors++;
        end
    endtask

    //////////////////////////////////////////////////
    // Interpreter of the loaded program
    //////////////////////////////////////////////////
    task automatic build_expected();
        int     pc;
        int     count;
        logic   halted;
        instr_t ins;
        mop_t   m;
        pc     = 0;
        count  = 0;
        halted = 1'b0;
        want_q.delete();
        while (!halted && count < MAX_INSTR) begin
            ins = prog[pc];
            count++;
            case (ins.opcode)
                JMP: pc = int'(ins.dst) % PROG_DEPTH;
                CALL: begin
                    ret_model   = (pc + 1) % PROG_DEPTH;
                    pc          = int'(ins.dst) % PROG_DEPTH;
                    frame_model = int'(ins.src0);
                end
                RET:  pc = ret_model;
                HALT: halted = 1'b1;
                default: begin
                    // Step-major, threads in order inside each step
                    for (int s = 0; s < step_count(ins.opcode); s++) begin
                        for (int t = 0; t < `SEQ_N_THREADS; t++) begin
                            m.csig = csig_t'(step_csig(ins.opcode, s));
                            m.dst  = thread_addr(t, ins.dst, frame_model);
                            m.src0 = thread_addr(t, ins.src0, frame_model);
                            m.src1 = thread_addr(t, ins.src1, frame_model);
                            want_q.push_back(m);
                        end
                    end
                    pc = (pc + 1) % PROG_DEPTH;
                end
            endcase
        end
        if (!halted) begin
            report_error("model did not reach HALT");
        end
    endtask

    always @(negedge clk) begin
        if (!rstn) begin
            frame_model = 0;
            ret_model   = 0;
            in_test     = 1'b0;
            started     = 1'b0;
            run_q       = 1'b0;
            busy_q      = 1'b0;
            want_q.delete();
        end else begin
            if (!started && (busy || mop_valid)) begin
                report_error("busy or mop_valid active before the first run");
            end
            if (run_q && !busy) begin
                report_error("busy did not rise after run");
            end
            if (run && !busy) begin
                test_errors = 0;
                beats       = 0;
                build_expected();
                in_test = 1'b1;
                started = 1'b1;
            end
            if (mop_valid) begin
                if (want_q.size() == 0) begin
                    report_error("micro-op issued with none expected");
                end else begin
                    want = want_q.pop_front();
                    compare_field("mop.csig", want.csig, mop.csig);
                    compare_field("mop.dst", 16'(want.dst), 16'(mop.dst));
                    compare_field("mop.src0", 16'(want.src0), 16'(mop.src0));
                    compare_field("mop.src1", 16'(want.src1), 16'(mop.src1));
                    beats++;
                end
            end
            if (in_test && busy_q && !busy) begin  // End of run
                if (want_q.size() != 0) begin
                    report_error($sformatf("missing micro-ops, %0d never issued",
                                           want_q.size()));
                end
                tests_done++;
                if (test_errors != 0) begin
                    tests_failed++;
                end
                $display("test %0d: %0d micro-ops checked, %0d errors, %s", tests_done,
                         beats, test_errors, (test_errors == 0) ? "ok" : "FAILED");
                in_test = 1'b0;
            end
            run_q  = run && !busy;
            busy_q = busy;
        end
    end

endmodule

`default_nettype wire

//--- sim/tb_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "seq_settings.svh"

module tb_top import seq_isa_pkg::*, seq_pipe_pkg::*; ();

    localparam int PROG_DEPTH      = 1 << `SEQ_PROG_AW;
    localparam int N_TESTS         = 9;
    // Read bubble plus 12 issue cycles for the longest op
    localparam int WATCHDOG_CYCLES = N_TESTS * PROG_DEPTH * 13 * 2;

    logic       clk;
    logic       rstn;
    logic       prog_we;
    prog_addr_t prog_addr;
    instr_t     prog_data;
    logic       run;
    logic       busy;
    logic       mop_valid;
    mop_t       mop;
    instr_t     prog [PROG_DEPTH];
    int         tests_done;
    int         tests_failed;
    int         error_count;

    tb_clock i_tb_clock (
        .clk  (clk),
        .rstn (rstn)
    );

    microcode_sequencer i_microcode_sequencer (
        .clk       (clk),
        .rstn      (rstn),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .run       (run),
        .busy      (busy),
        .mop_valid (mop_valid),
        .mop       (mop)
    );

    tb_checker i_tb_checker (
        .clk          (clk),
        .rstn         (rstn),
        .run          (run),
        .busy         (busy),
        .mop_valid    (mop_valid),
        .mop          (mop),
        .prog         (prog),
        .tests_done   (tests_done),
        .tests_failed (tests_failed),
        .error_count  (error_count)
    );

    //////////////////////////////////////////////////
    // Program generation
    //////////////////////////////////////////////////
    function automatic instr_t random_arith();
        instr_t ins;
        case ($urandom % 3)
            0:       ins.opcode = FP2_MUL;
            1:       ins.opcode = FP2_SQR;
            default: ins.opcode = ACC_SUB;
        endcase
        ins.dst  = field_t'($urandom);
        ins.src0 = field_t'($urandom);
        ins.src1 = field_t'($urandom);
        return ins;
    endfunction

    // Target sits in the low 6 bits of dst, top bit is don't care
    function automatic instr_t control_op(opcode_t op, int target, int offs);
        instr_t ins;
        ins.opcode = op;
        ins.dst    = field_t'(target + PROG_DEPTH * int'($urandom % 2));
        ins.src0   = field_t'(offs);
        ins.src1   = field_t'($urandom);
        return ins;
    endfunction

    task automatic fill_from(int from);
        for (int a = from; a < PROG_DEPTH; a++) begin
            prog[a] = random_arith();
        end
    endtask

    task automatic build_straight(int n);
        for (int a = 0; a < n; a++) begin
            prog[a] = random_arith();
        end
        prog[n] = control_op(HALT, 0, 0);
        fill_from(n + 1);
    endtask

    task automatic build_jump();
        for (int a = 0; a < 13; a++) begin
            prog[a] = random_arith();
        end
        prog[4]  = control_op(JMP, 9, 0);  // Skips 5 to 8
        prog[12] = control_op(HALT, 0, 0);
        fill_from(13);
    endtask

    task automatic build_call();
        for (int a = 0; a < 14; a++) begin
            prog[a] = random_arith();
        end
        prog[3]  = control_op(CALL, 10, 1 + int'($urandom % 127));
        prog[6]  = control_op(HALT, 0, 0);
        prog[13] = control_op(RET, 0, 0);  // Back to 4
        fill_from(14);
    endtask

    // Main body, HALT, then an optional subroutine ending in RET
    task automatic build_random();
        int len;
        int call_pos;
        int sub_len;
        len      = 8 + int'($urandom % 33);
        call_pos = ($urandom % 2 == 0) ? -1 : int'($urandom % len);
        sub_len  = 1 + int'($urandom % 6);
        for (int a = 0; a < len; a++) begin
            if (a == call_pos) begin
                prog[a] = control_op(CALL, len + 1, int'($urandom % 128));
            end else if ($urandom % 5 == 0) begin
                prog[a] = control_op(JMP, a + 1 + int'($urandom % (len - a)), 0);
            end else begin
                prog[a] = random_arith();
            end
        end
        prog[len] = control_op(HALT, 0, 0);
        for (int a = len + 1; a <= len + sub_len; a++) begin
            prog[a] = random_arith();
        end
        prog[len + sub_len + 1] = control_op(RET, 0, 0);
        fill_from(len + sub_len + 2);
    endtask

    //////////////////////////////////////////////////
    // DUT stimulus
    //////////////////////////////////////////////////
    task automatic load_program();
        for (int a = 0; a < PROG_DEPTH; a++) begin
            @(posedge clk);
            prog_we   <= 1'b1;
            prog_addr <= prog_addr_t'(a);
            prog_data <= prog[a];
        end
        @(posedge clk);
        prog_we <= 1'b0;
    endtask

    task automatic run_program();
        load_program();
        @(posedge clk);
        run <= 1'b1;
        @(posedge clk);
        run <= 1'b0;
        do begin
            @(negedge clk);
        end while (busy);
        repeat (2) @(posedge clk);  // Checker closes the test
    endtask

    initial begin
        prog_we   <= 1'b0;
        prog_addr <= '0;
        prog_data <= '0;
        run       <= 1'b0;
        void'($urandom(32'h87da1377));
        wait (rstn === 1'b1);
        repeat (20) @(posedge clk);  // Idle window after reset

        build_straight(12);
        run_program();
        build_jump();
        run_program();
        repeat (5) begin
            build_random();
            run_program();
        end
        build_call();
        run_program();
        build_straight(6);  // Reload, frame offset stays from the CALL
        run_program();

        if (tests_done != N_TESTS) begin
            $display("Only %0d of %0d tests completed", tests_done, N_TESTS);
        end
        $display("tests %0d, failed %0d, errors %0d", tests_done, tests_failed, error_count);
        if (error_count == 0 && tests_failed == 0 && tests_done == N_TESTS) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout, tests still running after %0d cycles", WATCHDOG_CYCLES);
        $display("sim failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- all.f
+incdir+verilog
verilog/seq_isa_pkg.sv
verilog/seq_pipe_pkg.sv
verilog/seq_fetch.sv
verilog/thread_lane.sv
verilog/mop_issue.sv
verilog/microcode_sequencer.sv
sim/tb_clock.sv
sim/tb_checker.sv
sim/tb_top.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the microcode sequencer testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

rm -rf obj_dir

verilator --binary --timing -j 0 -f all.f --top-module tb_top -o tb_top
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/tb_top > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "sim passed" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1
